// File: hw/ipv4_rx_consts.svh
`ifndef IPV4_RX_CONSTS_SVH
`define IPV4_RX_CONSTS_SVH

// ethernet framing
`define ETH_HDR_LEN     14                  // dst mac + src mac + ethertype
`define ETHERTYPE_IPV4  16'h0800
`define MAC_BROADCAST   48'hffff_ffff_ffff

// ipv4 header
`define IPV4_MIN_HDR    20                  // header bytes with IHL 5
`define IPV4_BROADCAST  32'hffff_ffff       // limited broadcast only

// status counters, both saturate at all ones
`define DROP_CNT_W      16

`endif

// File: hw/eth_pkg.sv
package eth_pkg;

  typedef logic [47:0] mac_addr_t;
  typedef logic [15:0] ethertype_t;   // big endian on the wire

  // header stripper states
  typedef enum logic [1:0] {
    ETH_HDR,   // collecting the header bytes
    ETH_PASS,  // frame accepted, bytes go straight to the ip stream
    ETH_DROP   // frame rejected, swallow bytes up to last
  } eth_state_t;

endpackage

// File: hw/ipv4_pkg.sv
package ipv4_pkg;

  typedef logic [31:0] ipv4_addr_t;
  typedef logic [15:0] ipv4_len_t;    // lengths in bytes
  typedef logic [7:0]  ipv4_proto_t;  // 17 is udp, 6 is tcp
  typedef logic [15:0] cks_t;         // ones' complement word

  // receiver states
  typedef enum logic [2:0] {
    IP_IDLE,   // waiting for byte 0 of a datagram
    IP_HDR,    // header and options, feeding the checksum
    IP_CHECK,  // one cycle to judge the header
    IP_PLD,    // forwarding payload through the output register
    IP_PAD,    // total length reached, eat ethernet padding
    IP_DROP    // rejected datagram, eat the rest
  } ipv4_state_t;

endpackage

// File: hw/eth_rx_parse.sv
`include "ipv4_rx_consts.svh"

module eth_rx_parse (
  input  logic                   clk,
  input  logic                   fsm_rst,
  input  logic [7:0]             in_data,
  input  logic                   in_valid,
  input  logic                   in_last,
  output logic                   in_ready,
  input  eth_pkg::mac_addr_t     dev_mac,
  output logic [7:0]             ip_data,
  output logic                   ip_valid,
  output logic                   ip_last,
  input  logic                   ip_ready,
  output logic [`DROP_CNT_W-1:0] eth_drop_cnt
);
  import eth_pkg::*;

  eth_state_t state;
  logic       armed;      // held low for one cycle out of reset
  logic [3:0] hdr_cnt;    // header byte index
  mac_addr_t  dst_mac;
  ethertype_t etype;
  ethertype_t etype_nxt;
  logic       in_xfer;
  logic       hdr_end;
  logic       keep;
  logic       drop_inc;

  assign in_xfer   = in_valid && in_ready;
  assign hdr_end   = (state == ETH_HDR) && (hdr_cnt == 4'(`ETH_HDR_LEN - 1));
  assign etype_nxt = {etype[7:0], in_data};  // second ethertype byte is on the bus now

  assign keep = ((dst_mac == dev_mac) || (dst_mac == `MAC_BROADCAST)) &&
                (etype_nxt == `ETHERTYPE_IPV4);

  // a frame ending inside the header has nothing to forward, count it too
  assign drop_inc = in_xfer && (state == ETH_HDR) && ((hdr_end && !keep) || in_last);

  // data path is combinational, only the handshake depends on state
  assign in_ready = (state == ETH_PASS) ? ip_ready : armed;
  assign ip_valid = (state == ETH_PASS) && in_valid;
  assign ip_data  = in_data;
  assign ip_last  = in_last;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state        <= ETH_HDR;
      armed        <= 1'b0;
      hdr_cnt      <= '0;
      eth_drop_cnt <= '0;
    end else begin
      armed <= 1'b1;
      if (drop_inc && (eth_drop_cnt != '1)) begin
        eth_drop_cnt <= eth_drop_cnt + 1'b1;
      end

      case (state)
        ETH_HDR: begin
          if (in_xfer) begin
            if (in_last) begin
              hdr_cnt <= '0;          // runt, start over on the next frame
            end else if (hdr_end) begin
              hdr_cnt <= '0;
              state   <= keep ? ETH_PASS : ETH_DROP;
            end else begin
              hdr_cnt <= hdr_cnt + 4'd1;
            end
          end
        end
        ETH_PASS, ETH_DROP: begin
          if (in_xfer && in_last) begin
            state <= ETH_HDR;
          end
        end
        default: state <= ETH_HDR;
      endcase
    end
  end

  // dst mac is bytes 0..5, ethertype ends up in the last two shifts
  always_ff @(posedge clk) begin
    if ((state == ETH_HDR) && in_xfer) begin
      etype <= etype_nxt;
      if (hdr_cnt < 4'd6) begin
        dst_mac <= {dst_mac[39:0], in_data};
      end
    end
  end

  // only frames that passed the address and ethertype filter reach the ip stream
  assert property (@(posedge clk) disable iff (fsm_rst)
    ip_valid |-> (etype == `ETHERTYPE_IPV4) &&
                 ((dst_mac == dev_mac) || (dst_mac == `MAC_BROADCAST)));

endmodule

// File: hw/ipv4_cks.sv
module ipv4_cks (
  input  logic       clk,
  input  logic       fsm_rst,
  input  logic       cks_clear,
  input  logic       cks_en,
  input  logic [7:0] cks_byte,
  output logic       cks_ok
);
  import ipv4_pkg::*;

  logic        odd;        // high byte already held, this one completes the word
  logic [7:0]  hi_byte;
  logic [19:0] sum;
  logic        odd_base;
  logic [19:0] sum_base;
  logic [19:0] sum_nxt;
  logic [16:0] fold1;
  cks_t        fold2;

  // clear arrives together with the first header byte
  assign odd_base = cks_clear ? 1'b0 : odd;
  assign sum_base = cks_clear ? '0 : sum;

  // carry nibble goes back in on every add, so 20 bits never overflow
  assign sum_nxt = odd_base ? ({4'd0, sum_base[15:0]} + {16'd0, sum_base[19:16]} +
                               {4'd0, hi_byte, cks_byte})
                            : sum_base;

  assign fold1 = {1'b0, sum_nxt[15:0]} + {13'd0, sum_nxt[19:16]};
  assign fold2 = fold1[15:0] + {15'd0, fold1[16]};

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      odd    <= 1'b0;
      sum    <= '0;
      cks_ok <= 1'b0;
    end else if (cks_en) begin
      odd    <= !odd_base;
      sum    <= sum_nxt;
      cks_ok <= (fold2 == 16'hffff);   // header incl. its checksum sums to -0
    end else if (cks_clear) begin
      odd    <= 1'b0;
      sum    <= '0;
      cks_ok <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (cks_en && !odd_base) begin
      hi_byte <= cks_byte;
    end
  end

endmodule

// File: hw/ipv4_rx.sv
`include "ipv4_rx_consts.svh"

module ipv4_rx (
  input  logic                   clk,
  input  logic                   fsm_rst,
  input  logic [7:0]             ip_data,
  input  logic                   ip_valid,
  input  logic                   ip_last,
  output logic                   ip_ready,
  input  ipv4_pkg::ipv4_addr_t   dev_ip,
  output logic                   cks_clear,
  output logic                   cks_en,
  output logic [7:0]             cks_byte,
  input  logic                   cks_ok,
  output logic [7:0]             pld_data,
  output logic                   pld_valid,
  output logic                   pld_last,
  output logic                   pld_err,
  input  logic                   pld_ready,
  output ipv4_pkg::ipv4_addr_t   pld_src_ip,
  output ipv4_pkg::ipv4_proto_t  pld_proto,
  output ipv4_pkg::ipv4_len_t    pld_len,
  output logic [`DROP_CNT_W-1:0] ip_drop_cnt
);
  import ipv4_pkg::*;

  ipv4_state_t state;
  logic [5:0]  hdr_cnt;     // index of the byte on the bus while in IP_HDR
  logic [3:0]  version;
  logic [3:0]  ihl;
  ipv4_len_t   hdr_len;     // 4*IHL, at least 20 so the fixed fields always land
  ipv4_len_t   tot_len;
  ipv4_proto_t proto;
  ipv4_addr_t  src_ip;
  ipv4_addr_t  dst_ip;
  ipv4_len_t   pld_size;
  ipv4_len_t   rem;         // payload bytes still to forward
  logic        ended;       // ip_last came with the final header byte
  logic        in_xfer;
  logic        hdr_end;
  logic        hdr_ok;
  logic        dst_ok;
  logic        accept;
  logic        last_pld;
  logic        pld_load;
  logic        drop_inc;

  assign in_xfer  = ip_valid && ip_ready;
  assign hdr_end  = (state == IP_HDR) && (hdr_cnt == hdr_len[5:0] - 6'd1);
  assign pld_size = tot_len - hdr_len;

  assign hdr_ok = (version == 4'd4) && (ihl >= 4'd5) && cks_ok && (tot_len >= hdr_len);
  assign dst_ok = (dst_ip == dev_ip) || (dst_ip == `IPV4_BROADCAST);
  // a frame that stopped at the header end can only pass with an empty payload
  assign accept = hdr_ok && dst_ok && !(ended && (pld_size != '0));

  assign last_pld = (rem == 16'd1);
  assign pld_load = (state == IP_PLD) && in_xfer;

  assign drop_inc = (in_xfer && ip_last &&
                     ((state == IP_IDLE) || ((state == IP_HDR) && !hdr_end))) ||
                    ((state == IP_CHECK) && !accept);

  // every header byte feeds the checksum, ready is high in IDLE and HDR
  assign cks_clear = ip_valid && (state == IP_IDLE);
  assign cks_en    = ip_valid && ((state == IP_IDLE) || (state == IP_HDR));
  assign cks_byte  = ip_data;

  always_comb begin
    case (state)
      IP_CHECK: ip_ready = 1'b0;
      IP_PLD:   ip_ready = !pld_valid || pld_ready;  // output register has room
      default:  ip_ready = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state       <= IP_IDLE;
      hdr_cnt     <= '0;
      ended       <= 1'b0;
      ip_drop_cnt <= '0;
    end else begin
      if (drop_inc && (ip_drop_cnt != '1)) begin
        ip_drop_cnt <= ip_drop_cnt + 1'b1;
      end

      case (state)
        IP_IDLE: begin
          if (in_xfer) begin
            hdr_cnt <= 6'd1;
            state   <= ip_last ? IP_IDLE : IP_HDR;
          end
        end
        IP_HDR: begin
          if (in_xfer) begin
            hdr_cnt <= hdr_cnt + 6'd1;
            if (hdr_end) begin
              ended <= ip_last;
              state <= IP_CHECK;
            end else if (ip_last) begin
              state <= IP_IDLE;          // truncated header
            end
          end
        end
        IP_CHECK: begin
          if (!accept) begin
            state <= ended ? IP_IDLE : IP_DROP;
          end else if (!pld_valid) begin
            // meta outputs still belong to a stalled last beat until it leaves
            if (ended) begin
              state <= IP_IDLE;
            end else begin
              state <= (pld_size == '0) ? IP_PAD : IP_PLD;
            end
          end
        end
        IP_PLD: begin
          if (in_xfer && (last_pld || ip_last)) begin
            state <= ip_last ? IP_IDLE : IP_PAD;
          end
        end
        IP_PAD, IP_DROP: begin
          if (in_xfer && ip_last) begin
            state <= IP_IDLE;
          end
        end
        default: state <= IP_IDLE;
      endcase
    end
  end

  // header fields at fixed offsets, options are skipped by the counter
  always_ff @(posedge clk) begin
    if ((state == IP_IDLE) && in_xfer) begin
      version <= ip_data[7:4];
      ihl     <= ip_data[3:0];
      hdr_len <= (ip_data[3:0] < 4'd5) ? ipv4_len_t'(`IPV4_MIN_HDR)
                                       : {10'd0, ip_data[3:0], 2'b00};
    end
    if ((state == IP_HDR) && in_xfer) begin
      case (hdr_cnt)
        6'd2:                      tot_len[15:8] <= ip_data;
        6'd3:                      tot_len[7:0]  <= ip_data;
        6'd9:                      proto         <= ip_data;
        6'd12, 6'd13, 6'd14, 6'd15: src_ip       <= {src_ip[23:0], ip_data};
        6'd16, 6'd17, 6'd18, 6'd19: dst_ip       <= {dst_ip[23:0], ip_data};
        default: ;
      endcase
    end
    if ((state == IP_CHECK) && accept && !pld_valid) begin
      pld_src_ip <= src_ip;
      pld_proto  <= proto;
      pld_len    <= pld_size;
      rem        <= pld_size;
    end
    if (pld_load) begin
      rem      <= rem - 16'd1;
      pld_data <= ip_data;
    end
  end

  // single output register
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      pld_valid <= 1'b0;
      pld_last  <= 1'b0;
      pld_err   <= 1'b0;
    end else if (pld_load) begin
      pld_valid <= 1'b1;
      pld_last  <= last_pld || ip_last;
      pld_err   <= ip_last && !last_pld;   // frame ran out before total length
    end else if (pld_ready) begin
      pld_valid <= 1'b0;
    end
  end

  assert property (@(posedge clk) disable iff (fsm_rst)
    pld_valid && !pld_ready |=>
      pld_valid && $stable(pld_data) && $stable(pld_last) && $stable(pld_err));

  // payload only flows behind a header that passed every check
  assert property (@(posedge clk) disable iff (fsm_rst)
    pld_load |-> hdr_ok && dst_ok);

endmodule

// File: hw/ipv4_rx_top.sv
`include "ipv4_rx_consts.svh"

module ipv4_rx_top (
  input  logic                   clk,
  input  logic                   fsm_rst,
  input  logic [7:0]             in_data,
  input  logic                   in_valid,
  input  logic                   in_last,
  output logic                   in_ready,
  input  eth_pkg::mac_addr_t     dev_mac,
  input  ipv4_pkg::ipv4_addr_t   dev_ip,
  output logic [7:0]             pld_data,
  output logic                   pld_valid,
  output logic                   pld_last,
  output logic                   pld_err,
  input  logic                   pld_ready,
  output ipv4_pkg::ipv4_addr_t   pld_src_ip,
  output ipv4_pkg::ipv4_proto_t  pld_proto,
  output ipv4_pkg::ipv4_len_t    pld_len,
  output logic [`DROP_CNT_W-1:0] eth_drop_cnt,
  output logic [`DROP_CNT_W-1:0] ip_drop_cnt
);

  // stream after the ethernet header
  logic [7:0] ip_data;
  logic       ip_valid;
  logic       ip_last;
  logic       ip_ready;

  // checksum side channel
  logic       cks_clear;
  logic       cks_en;
  logic [7:0] cks_byte;
  logic       cks_ok;

  eth_rx_parse u_eth_parse (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .in_data      (in_data),
    .in_valid     (in_valid),
    .in_last      (in_last),
    .in_ready     (in_ready),
    .dev_mac      (dev_mac),
    .ip_data      (ip_data),
    .ip_valid     (ip_valid),
    .ip_last      (ip_last),
    .ip_ready     (ip_ready),
    .eth_drop_cnt (eth_drop_cnt)
  );

  ipv4_rx u_ipv4_rx (
    .clk         (clk),
    .fsm_rst     (fsm_rst),
    .ip_data     (ip_data),
    .ip_valid    (ip_valid),
    .ip_last     (ip_last),
    .ip_ready    (ip_ready),
    .dev_ip      (dev_ip),
    .cks_clear   (cks_clear),
    .cks_en      (cks_en),
    .cks_byte    (cks_byte),
    .cks_ok      (cks_ok),
    .pld_data    (pld_data),
    .pld_valid   (pld_valid),
    .pld_last    (pld_last),
    .pld_err     (pld_err),
    .pld_ready   (pld_ready),
    .pld_src_ip  (pld_src_ip),
    .pld_proto   (pld_proto),
    .pld_len     (pld_len),
    .ip_drop_cnt (ip_drop_cnt)
  );

  ipv4_cks u_ipv4_cks (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .cks_clear (cks_clear),
    .cks_en    (cks_en),
    .cks_byte  (cks_byte),
    .cks_ok    (cks_ok)
  );

endmodule

// File: dv/ipv4_rx_tb.sv
`include "ipv4_rx_consts.svh"

module ipv4_rx_tb;
  import eth_pkg::*;
  import ipv4_pkg::*;

  typedef logic [7:0] byte_q_t[$];

  localparam int         N_RAND     = 200;
  localparam int         N_DIRECTED = 9;
  localparam int         N_FRAMES   = N_RAND + N_DIRECTED;
  localparam mac_addr_t  DEV_MAC    = 48'h02_12_34_56_78_9a;
  localparam mac_addr_t  OTHER_MAC  = 48'h02_00_00_00_00_01;
  localparam ipv4_addr_t DEV_IP     = 32'hc0a8_0117;
  localparam ipv4_addr_t OTHER_IP   = 32'hc0a8_0163;

  logic                   clk;
  logic                   fsm_rst;
  logic [7:0]             in_data;
  logic                   in_valid;
  logic                   in_last;
  logic                   in_ready;
  mac_addr_t              dev_mac;
  ipv4_addr_t             dev_ip;
  logic [7:0]             pld_data;
  logic                   pld_valid;
  logic                   pld_last;
  logic                   pld_err;
  logic                   pld_ready;
  ipv4_addr_t             pld_src_ip;
  ipv4_proto_t            pld_proto;
  ipv4_len_t              pld_len;
  logic [`DROP_CNT_W-1:0] eth_drop_cnt;
  logic [`DROP_CNT_W-1:0] ip_drop_cnt;

  int errors;
  int frames_sent;
  int gap_pct;        // chance of an idle cycle before each input byte
  int stall_pct;      // chance of pld_ready low
  int exp_eth;
  int exp_ip;

  // expected packets, payload bytes of all of them in one flat queue
  logic [7:0]  exp_bytes[$];
  int          exp_cnt[$];
  ipv4_addr_t  exp_src[$];
  ipv4_proto_t exp_proto[$];
  ipv4_len_t   exp_len[$];
  logic        exp_err[$];

  logic [7:0]  got_bytes[$];
  ipv4_addr_t  got_src;
  ipv4_proto_t got_proto;
  ipv4_len_t   got_len;
  logic        got_err;
  event        pkt_done;
  logic        held;          // a beat sat stalled on the previous edge
  logic [9:0]  held_beat;     // data, last, err of that beat

  ipv4_rx_top UUT (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .in_data      (in_data),
    .in_valid     (in_valid),
    .in_last      (in_last),
    .in_ready     (in_ready),
    .dev_mac      (dev_mac),
    .dev_ip       (dev_ip),
    .pld_data     (pld_data),
    .pld_valid    (pld_valid),
    .pld_last     (pld_last),
    .pld_err      (pld_err),
    .pld_ready    (pld_ready),
    .pld_src_ip   (pld_src_ip),
    .pld_proto    (pld_proto),
    .pld_len      (pld_len),
    .eth_drop_cnt (eth_drop_cnt),
    .ip_drop_cnt  (ip_drop_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_val(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  // ones' complement sum of n bytes taken as big endian words
  function automatic logic [15:0] ones_sum(input byte_q_t b, input int start, input int n);
    logic [31:0] acc;
    acc = '0;
    for (int i = 0; i < n; i += 2) begin
      acc += {b[start + i], b[start + i + 1]};
    end
    while (acc[31:16] != '0) begin
      acc = acc[15:0] + acc[31:16];
    end
    return acc[15:0];
  endfunction

  // stage 0 accepted, 1 dropped by ethernet filter, 2 dropped by ipv4 checks
  function automatic void ref_frame(input byte_q_t f, input mac_addr_t mac,
      input ipv4_addr_t ip, output int stage, output byte_q_t pld, output ipv4_addr_t src,
      output ipv4_proto_t proto, output ipv4_len_t len, output logic err);
    logic [7:0] vihl;
    mac_addr_t  dst;
    ipv4_addr_t dip;
    int         hlen;
    int         tot;
    int         avail;
    pld   = {};
    src   = '0;
    proto = '0;
    len   = '0;
    err   = 1'b0;
    stage = 1;
    if (f.size() <= `ETH_HDR_LEN) return;       // nothing left after the header
    dst = {f[0], f[1], f[2], f[3], f[4], f[5]};
    if ((dst != mac && dst != `MAC_BROADCAST) || {f[12], f[13]} != `ETHERTYPE_IPV4) return;
    stage = 2;
    vihl  = f[14];
    hlen  = (vihl[3:0] < 5) ? `IPV4_MIN_HDR : 4 * vihl[3:0];
    avail = f.size() - `ETH_HDR_LEN - hlen;     // bytes after the ipv4 header
    if (avail < 0) return;
    tot = {f[16], f[17]};
    dip = {f[30], f[31], f[32], f[33]};
    if (vihl[7:4] != 4 || vihl[3:0] < 5 || ones_sum(f, 14, hlen) != 16'hffff) return;
    if (tot < hlen || (dip != ip && dip != `IPV4_BROADCAST)) return;
    len = tot - hlen;
    if (avail == 0 && len != 0) return;  // no byte left to carry the error flag
    stage = 0;
    src   = {f[26], f[27], f[28], f[29]};
    proto = f[23];
    err   = (avail < len);
    for (int i = 0; i < len && i < avail; i++) begin
      pld.push_back(f[`ETH_HDR_LEN + hlen + i]);
    end
  endfunction

  task automatic build_frame(input mac_addr_t dmac, input ethertype_t etype,
      input logic [3:0] ver, input logic [3:0] ihl, input ipv4_addr_t dip,
      input ipv4_proto_t proto, input int plen, input int pad, input int cut,
      input logic bad_cks, output byte_q_t f);
    byte_q_t      hdr;
    logic [159:0] base;
    logic [15:0]  tot;
    logic [15:0]  cks;
    ipv4_addr_t   sip;
    f   = {};
    hdr = {};
    sip = $urandom;
    tot = 16'(4 * ihl + plen);
    for (int i = 0; i < 6; i++) begin
      f.push_back(dmac[47 - 8 * i -: 8]);
    end
    for (int i = 0; i < 6; i++) begin
      f.push_back(8'($urandom));   // source mac
    end
    f.push_back(etype[15:8]);
    f.push_back(etype[7:0]);
    base = {ver, ihl, 8'h00, tot, 16'($urandom), 16'h4000, 8'h40, proto, 16'h0000, sip, dip};
    for (int i = 0; i < 20; i++) begin
      hdr.push_back(base[159 - 8 * i -: 8]);
    end
    for (int i = 20; i < 4 * ihl; i++) begin
      hdr.push_back(8'($urandom));   // options
    end
    cks     = ~ones_sum(hdr, 0, hdr.size());
    hdr[10] = cks[15:8];
    hdr[11] = cks[7:0] ^ {7'd0, bad_cks};
    foreach (hdr[i]) f.push_back(hdr[i]);
    repeat (plen + pad) f.push_back(8'($urandom));
    repeat (cut) void'(f.pop_back());
  endtask

  // model first, then drive, then wait for the payload and the counters
  task automatic send_frame(input byte_q_t f);
    int          stage;
    byte_q_t     pld;
    ipv4_addr_t  src;
    ipv4_proto_t proto;
    ipv4_len_t   len;
    logic        err;
    ref_frame(f, DEV_MAC, DEV_IP, stage, pld, src, proto, len, err);
    if (stage == 1) begin
      exp_eth++;
    end else if (stage == 2) begin
      exp_ip++;
    end else if (pld.size() > 0) begin
      foreach (pld[i]) exp_bytes.push_back(pld[i]);
      exp_src.push_back(src);
      exp_proto.push_back(proto);
      exp_len.push_back(len);
      exp_err.push_back(err);
      exp_cnt.push_back(pld.size());
    end
    frames_sent++;
    foreach (f[i]) begin
      while ($urandom_range(99) < gap_pct) begin
        in_valid <= 1'b0;
        @(posedge clk);
      end
      in_data  <= f[i];
      in_valid <= 1'b1;
      in_last  <= (i == f.size() - 1);
      @(posedge clk);
      while (!in_ready) @(posedge clk);
    end
    in_valid <= 1'b0;
    in_last  <= 1'b0;
    while (exp_cnt.size() != 0) @(posedge clk);
    repeat (3) @(posedge clk);   // drop counts settle two cycles after the decision
    check_val("eth_drop_cnt", exp_eth, eth_drop_cnt);
    check_val("ip_drop_cnt", exp_ip, ip_drop_cnt);
  endtask

  always @(posedge clk) begin
    pld_ready <= ($urandom_range(99) >= stall_pct);
  end

  // monitor, meta taken on the first beat of a packet and held to the last
  always @(posedge clk) begin
    if (!fsm_rst && held) begin
      check_val("pld_hold", {1'b1, held_beat}, {pld_valid, pld_data, pld_last, pld_err});
    end
    held      = !fsm_rst && pld_valid && !pld_ready;
    held_beat = {pld_data, pld_last, pld_err};
    if (!fsm_rst && pld_valid && pld_ready) begin
      if (got_bytes.size() == 0) begin
        got_src   = pld_src_ip;
        got_proto = pld_proto;
        got_len   = pld_len;
      end else begin
        check_val("pld_meta", {got_src, got_proto, got_len},
                  {pld_src_ip, pld_proto, pld_len});
      end
      got_bytes.push_back(pld_data);
      if (pld_last) begin
        got_err = pld_err;
        -> pkt_done;
      end
    end
  end

  initial begin
    int n;
    forever begin
      @(pkt_done);
      if (exp_cnt.size() == 0) begin
        errors++;
        $display("unexpected packet of %0d bytes on the payload output", got_bytes.size());
      end else begin
        n = exp_cnt.pop_front();
        check_val("pld_count", n, got_bytes.size());
        for (int i = 0; i < n; i++) begin
          check_val("pld_data", exp_bytes.pop_front(), (i < got_bytes.size()) ? got_bytes[i] : 'x);
        end
        check_val("pld_src_ip", exp_src.pop_front(), got_src);
        check_val("pld_proto", exp_proto.pop_front(), got_proto);
        check_val("pld_len", exp_len.pop_front(), got_len);
        check_val("pld_err", exp_err.pop_front(), got_err);
      end
      got_bytes = {};
    end
  end

  initial begin
    #(20 * 3000 * N_FRAMES);
    $display("timeout: the run did not finish within %0d cycles", 3000 * N_FRAMES);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    byte_q_t     f;
    int          r;
    int          plen;
    int          pad;
    mac_addr_t   dmac;
    ipv4_addr_t  dip;
    void'($urandom(32'h63254f14));
    errors      = 0;
    frames_sent = 0;
    exp_eth     = 0;
    exp_ip      = 0;
    gap_pct     = 20;
    stall_pct   = 30;
    fsm_rst     = 1'b1;
    in_data     = '0;
    in_valid    = 1'b0;
    in_last     = 1'b0;
    pld_ready   = 1'b0;
    dev_mac     = DEV_MAC;
    dev_ip      = DEV_IP;
    repeat (8) @(posedge clk);
    fsm_rst <= 1'b0;
    repeat (2) @(posedge clk);

    // unicast udp, plain header
    build_frame(DEV_MAC, `ETHERTYPE_IPV4, 4'd4, 4'd5, DEV_IP, 8'd17, 32, 0, 0, 1'b0, f);
    send_frame(f);
    // options, broadcast, ethernet padding
    build_frame(`MAC_BROADCAST, `ETHERTYPE_IPV4, 4'd4, 4'd7, `IPV4_BROADCAST, 8'd6, 6, 12, 0,
                1'b0, f);
    send_frame(f);
    // rejections, two by the ethernet filter and three by the ipv4 checks
    build_frame(OTHER_MAC, `ETHERTYPE_IPV4, 4'd4, 4'd5, DEV_IP, 8'd17, 10, 0, 0, 1'b0, f);
    send_frame(f);
    build_frame(DEV_MAC, 16'h86dd, 4'd4, 4'd5, DEV_IP, 8'd17, 10, 0, 0, 1'b0, f);
    send_frame(f);
    build_frame(DEV_MAC, `ETHERTYPE_IPV4, 4'd4, 4'd5, DEV_IP, 8'd17, 10, 0, 0, 1'b1, f);
    send_frame(f);
    build_frame(DEV_MAC, `ETHERTYPE_IPV4, 4'd6, 4'd5, DEV_IP, 8'd17, 10, 0, 0, 1'b0, f);
    send_frame(f);
    build_frame(DEV_MAC, `ETHERTYPE_IPV4, 4'd4, 4'd5, OTHER_IP, 8'd17, 10, 0, 0, 1'b0, f);
    send_frame(f);
    // truncated before total length
    build_frame(DEV_MAC, `ETHERTYPE_IPV4, 4'd4, 4'd5, DEV_IP, 8'd17, 40, 0, 15, 1'b0, f);
    send_frame(f);
    // empty payload followed by padding
    build_frame(DEV_MAC, `ETHERTYPE_IPV4, 4'd4, 4'd6, DEV_IP, 8'd1, 0, 20, 0, 1'b0, f);
    send_frame(f);

    // random frames under heavy back-pressure
    gap_pct   = 40;
    stall_pct = 70;
    for (int k = 0; k < N_RAND; k++) begin
      r    = $urandom_range(15);
      plen = $urandom_range(48);
      pad  = $urandom_range(1) ? $urandom_range(20) : 0;
      dmac = (r == 0) ? OTHER_MAC : (r == 1) ? `MAC_BROADCAST : DEV_MAC;
      dip  = (r == 4) ? OTHER_IP : (r == 5) ? `IPV4_BROADCAST : DEV_IP;
      build_frame(dmac, (r == 2) ? 16'h0806 : `ETHERTYPE_IPV4, (r == 3) ? 4'd6 : 4'd4,
                  4'(5 + $urandom_range(3)), dip, 8'($urandom), plen, pad,
                  (r == 7) ? $urandom_range(plen + pad + 8) : 0, (r == 6), f);
      send_frame(f);
    end

    // beats without a closing last would otherwise go unseen
    check_val("pld_beats_left", 0, got_bytes.size());

    $display("errors: %0d, frames sent: %0d", errors, frames_sent);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: ipv4_rx.f
+incdir+hw
hw/eth_pkg.sv
hw/ipv4_pkg.sv
hw/eth_rx_parse.sv
hw/ipv4_cks.sv
hw/ipv4_rx.sv
hw/ipv4_rx_top.sv
dv/ipv4_rx_tb.sv

// File: Bender.yml
package:
  name: ipv4_rx

export_include_dirs:
  - hw

sources:
  - files:
      - hw/eth_pkg.sv
      - hw/ipv4_pkg.sv
      - hw/eth_rx_parse.sv
      - hw/ipv4_cks.sv
      - hw/ipv4_rx.sv
      - hw/ipv4_rx_top.sv
  - target: test
    files:
      - dv/ipv4_rx_tb.sv
